// ==== filelist.f ====
logic/cpuPkg.sv
logic/instrDecoder.sv
logic/dualDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/resultStage.sv
logic/issueSliceTop.sv
bench/tbIssueSlice.sv

// ==== Bender.yml ====
package:
  name: issueSlice

sources:
  - files:
      - logic/cpuPkg.sv
      - logic/instrDecoder.sv
      - logic/dualDecode.sv
      - logic/regFile.sv
      - logic/aluExecute.sv
      - logic/resultStage.sv
      - logic/issueSliceTop.sv
  - target: simulation
    files:
      - bench/tbIssueSlice.sv

// ==== bench/tbIssueSlice.sv ====
`timescale 1ns/10ps

module tbIssueSlice;
    import cpuPkg::*;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 5;
    // pairs issued per test including the drain
    localparam int ResetPairs = 3;
    localparam int AluPairs = 28;
    localparam int DepPairs = 9;
    localparam int ZeroPairs = 9;
    localparam int FlagPairs = 10;
    localparam int MarginCycles = 40;
    localparam int RunCycles = ResetCycles + ResetPairs + AluPairs + DepPairs + ZeroPairs
                               + FlagPairs + MarginCycles;

    // operations swept by the ALU test
    localparam logic [6*11-1:0] RFuncts = {FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnNor,
                                           FnSlt, FnSltu, FnSll, FnSrl, FnSra};
    localparam logic [6*7-1:0] IOps = {OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};

    logic clk;
    logic arstN;
    fetchData_t [Slots-1:0] fetchIn;
    resultData_t [Slots-1:0] resultOut;

    integer seed;
    addr_t pcNext;
    // architectural register state
    word_t shadow [32];
    // expected results per slot in issue order
    resultData_t expOlder [$];
    resultData_t expYounger [$];

    issueSliceTop #(
        .RegCount(32)
    ) i_dut (
        .clk(clk),
        .arstN(arstN),
        .fetchIn(fetchIn),
        .resultOut(resultOut)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic word_t encodeR(logic [5:0] fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                      shamt_t sh);
        return {OpSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encodeI(logic [5:0] op, regAddr_t rs, regAddr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fetchData_t slotOf(logic valid, word_t instr, logic pred);
        fetchData_t f;
        f.valid = valid;
        f.rawInstr = instr;
        f.pc = '0;
        f.predBranch = pred;
        return f;
    endfunction

    // valid slot without prediction
    function automatic fetchData_t live(word_t instr);
        return slotOf(1'b1, instr, 1'b0);
    endfunction

    // reference model of one slot that updates the shadow registers
    task automatic predictSlot(input fetchData_t f, output resultData_t r);
        logic [5:0] op;
        logic [5:0] fn;
        regAddr_t rs;
        regAddr_t rt;
        shamt_t sh;
        word_t a;
        word_t b;
        word_t sImm;
        word_t zImm;
        logic alu;
        r = '0;
        op = f.rawInstr[31:26];
        fn = f.rawInstr[5:0];
        rs = f.rawInstr[25:21];
        rt = f.rawInstr[20:16];
        sh = f.rawInstr[10:6];
        a = shadow[rs];
        b = shadow[rt];
        sImm = {{16{f.rawInstr[15]}}, f.rawInstr[15:0]};
        zImm = {16'h0, f.rawInstr[15:0]};
        alu = 1'b1;
        r.dest = rt;
        case (op)
            OpSpecial: begin
                r.dest = f.rawInstr[15:11];
                case (fn)
                    FnAddu: r.value = a + b;
                    FnSubu: r.value = a - b;
                    FnAnd: r.value = a & b;
                    FnOr: r.value = a | b;
                    FnXor: r.value = a ^ b;
                    FnNor: r.value = ~(a | b);
                    FnSlt: r.value = {31'b0, $signed(a) < $signed(b)};
                    FnSltu: r.value = {31'b0, a < b};
                    FnSll: r.value = b << sh;
                    FnSrl: r.value = b >> sh;
                    FnSra: r.value = $signed(b) >>> sh;
                    FnJr: alu = 1'b0;
                    default: begin
                        alu = 1'b0;
                        r.reserved = 1'b1;
                    end
                endcase
            end
            OpAddiu: r.value = a + sImm;
            OpSlti: r.value = {31'b0, $signed(a) < $signed(sImm)};
            // unsigned compare with the immediate still sign extended
            OpSltiu: r.value = {31'b0, a < sImm};
            OpAndi: r.value = a & zImm;
            OpOri: r.value = a | zImm;
            OpXori: r.value = a ^ zImm;
            OpLui: r.value = {f.rawInstr[15:0], 16'h0};
            OpJ, OpJal, OpBeq, OpBne: alu = 1'b0;
            OpCop0: begin
                alu = 1'b0;
                r.reserved = !(rs == 5'd0 || rs == 5'd4);
            end
            default: begin
                alu = 1'b0;
                r.reserved = 1'b1;
            end
        endcase
        r.valid = f.valid;
        r.pc = f.pc;
        // jr ra counts as a predicted return
        r.predBranch = f.predBranch || (op == OpSpecial && fn == FnJr && rs == 5'd31);
        r.wrEn = f.valid && alu && r.dest != 5'd0;
        r.reserved = r.reserved && f.valid;
        if (r.wrEn) begin
            shadow[r.dest] = r.value;
        end
    endtask

    task automatic compareSlot(input int slot, input resultData_t got, input resultData_t exp);
        string base;
        base = $sformatf("resultOut[%0d]", slot);
        checkValue({base, ".valid"}, got.valid, exp.valid);
        checkValue({base, ".wrEn"}, got.wrEn, exp.wrEn);
        checkValue({base, ".reserved"}, got.reserved, exp.reserved);
        if (exp.valid) begin
            checkValue({base, ".pc"}, got.pc, exp.pc);
            checkValue({base, ".predBranch"}, got.predBranch, exp.predBranch);
        end
        if (exp.wrEn) begin
            checkValue({base, ".dest"}, got.dest, exp.dest);
            checkValue({base, ".value"}, got.value, exp.value);
        end
    endtask

    // drive one pair at the falling edge and check the pair from one cycle earlier
    task automatic issuePair(input fetchData_t older, input fetchData_t younger);
        resultData_t exp1;
        resultData_t exp0;
        older.pc = pcNext;
        younger.pc = pcNext + 4;
        pcNext = pcNext + 8;
        fetchIn[1] = older;
        fetchIn[0] = younger;
        // older slot first so the younger one sees its write
        predictSlot(older, exp1);
        predictSlot(younger, exp0);
        expOlder.push_back(exp1);
        expYounger.push_back(exp0);
        @(negedge clk);
        if (expOlder.size() >= 2) begin
            compareSlot(1, resultOut[1], expOlder.pop_front());
            compareSlot(0, resultOut[0], expYounger.pop_front());
        end
    endtask

    task automatic drainPipe();
        issuePair(slotOf(1'b0, '0, 1'b0), slotOf(1'b0, '0, 1'b0));
        issuePair(slotOf(1'b0, '0, 1'b0), slotOf(1'b0, '0, 1'b0));
    endtask

    task automatic resetState();
        repeat (ResetCycles) begin
            @(negedge clk);
            checkValue("resultOut[1].valid", resultOut[1].valid, 1'b0);
            checkValue("resultOut[0].valid", resultOut[0].valid, 1'b0);
            checkValue("resultOut[1].wrEn", resultOut[1].wrEn, 1'b0);
            checkValue("resultOut[0].wrEn", resultOut[0].wrEn, 1'b0);
        end
        arstN = 1'b1;
        // never written registers read as zero
        issuePair(live(encodeR(FnAddu, 28, 29, 3, 0)), live(encodeR(FnOr, 30, 31, 4, 0)));
        checkValue("resultOut[1].valid", resultOut[1].valid, 1'b0);
        checkValue("resultOut[0].valid", resultOut[0].valid, 1'b0);
        checkValue("resultOut[1].wrEn", resultOut[1].wrEn, 1'b0);
        checkValue("resultOut[0].wrEn", resultOut[0].wrEn, 1'b0);
        drainPipe();
    endtask

    task automatic aluAndImmediate();
        word_t rnd;
        for (int round = 0; round < 2; round++) begin
            rnd = $random(seed);
            issuePair(live(encodeI(OpLui, 0, 1, rnd[31:16])),
                      live(encodeI(OpLui, 0, 2, rnd[15:0])));
            rnd = $random(seed);
            issuePair(live(encodeI(OpOri, 1, 1, rnd[31:16])),
                      live(encodeI(OpOri, 2, 2, rnd[15:0])));
            for (int i = 0; i < 11; i++) begin
                rnd = $random(seed);
                issuePair(live(encodeR(RFuncts[i*6 +: 6], 1, 2, 5'(10 + i), rnd[20:16])),
                          live(encodeI(IOps[(i % 7)*6 +: 6], 5'(1 + i % 2), 5'(20 + i),
                                       rnd[15:0])));
            end
        end
        drainPipe();
    endtask

    task automatic dependencies();
        word_t rnd;
        rnd = $random(seed);
        // slot 0 reads slot 1 of the same pair
        issuePair(live(encodeR(FnAddu, 1, 2, 5, 0)), live(encodeR(FnSubu, 5, 1, 6, 0)));
        issuePair(live(encodeR(FnAddu, 5, 6, 7, 0)), live(encodeR(FnAddu, 7, 7, 8, 0)));
        // back-to-back and two apart
        issuePair(live(encodeR(FnXor, 8, 5, 9, 0)), live(encodeI(OpOri, 6, 10, rnd[15:0])));
        issuePair(live(encodeR(FnSltu, 9, 10, 11, 0)), live(encodeR(FnSra, 0, 8, 12, rnd[20:16])));
        // chained update of one register inside a pair
        issuePair(live(encodeI(OpAddiu, 5, 5, rnd[31:16])),
                  live(encodeI(OpAddiu, 5, 5, rnd[15:0])));
        issuePair(live(encodeR(FnAddu, 5, 12, 13, 0)), live(encodeR(FnSubu, 13, 5, 14, 0)));
        issuePair(slotOf(1'b0, '0, 1'b0), live(encodeR(FnAddu, 5, 13, 15, 0)));
        drainPipe();
    endtask

    task automatic zeroAndConflicts();
        word_t rnd;
        rnd = $random(seed);
        // writes to r0 are dropped at every distance
        issuePair(live(encodeI(OpAddiu, 1, 0, rnd[15:0])), live(encodeR(FnAddu, 0, 1, 16, 0)));
        issuePair(live(encodeR(FnAddu, 0, 2, 17, 0)), live(encodeI(OpLui, 0, 0, rnd[31:16])));
        issuePair(live(encodeR(FnOr, 1, 2, 0, 0)), live(encodeR(FnAddu, 0, 0, 18, 0)));
        rnd = $random(seed);
        // both slots write r19 and younger slot 0 wins
        issuePair(live(encodeI(OpOri, 0, 19, rnd[31:16])), live(encodeI(OpOri, 0, 19, rnd[15:0])));
        issuePair(live(encodeR(FnAddu, 19, 0, 20, 0)), live(encodeR(FnAddu, 19, 19, 21, 0)));
        issuePair(slotOf(1'b0, '0, 1'b0), live(encodeR(FnAddu, 19, 0, 22, 0)));
        issuePair(slotOf(1'b0, '0, 1'b0), live(encodeR(FnAddu, 19, 0, 23, 0)));
        drainPipe();
    endtask

    task automatic bubblesAndFlags();
        word_t rnd;
        rnd = $random(seed);
        // bubbles carry instructions that must not commit
        issuePair(live(encodeI(OpAddiu, 1, 24, rnd[15:0])),
                  slotOf(1'b0, encodeI(OpAddiu, 0, 24, 16'h0), 1'b1));
        issuePair(slotOf(1'b0, encodeI(OpAddiu, 0, 25, 16'h1), 1'b0),
                  live(encodeR(FnAddu, 24, 0, 25, 0)));
        // return through ra versus another register
        issuePair(live(encodeR(FnJr, 31, 0, 0, 0)), live(encodeR(FnJr, 5, 0, 0, 0)));
        issuePair(slotOf(1'b1, encodeR(FnJr, 5, 0, 0, 0), 1'b1),
                  slotOf(1'b1, encodeR(FnJr, 31, 0, 0, 0), 1'b1));
        // undefined opcode then undefined function code
        issuePair(live({6'h3f, 5'd1, 5'd26, 16'h1234}), live(encodeR(6'h01, 1, 2, 26, 0)));
        issuePair(slotOf(1'b0, '0, 1'b0), live(encodeR(FnAddu, 26, 0, 27, 0)));
        // branch and jumps leave the registers alone
        issuePair(live(encodeI(OpBeq, 1, 2, 16'h4)), live({OpJ, 26'h40}));
        issuePair(live({OpJal, 26'h80}), live(encodeR(FnAddu, 31, 0, 28, 0)));
        drainPipe();
    endtask

    // watchdog sized from the test lengths
    initial begin
        #(RunCycles * ClkPeriod);
        $display("timeout: the directed tests did not complete in time");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 6;
        pcNext = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        clk = 1'b0;
        arstN = 1'b0;
        fetchIn = '0;
        resetState();
        aluAndImmediate();
        dependencies();
        zeroAndConflicts();
        bubblesAndFlags();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== logic/issueSliceTop.sv ====
`timescale 1ns/10ps

module issueSliceTop #(
    parameter int RegCount = 32
) (
    input logic clk,
    input logic arstN,
    input cpuPkg::fetchData_t [cpuPkg::Slots-1:0] fetchIn,
    output cpuPkg::resultData_t [cpuPkg::Slots-1:0] resultOut
);
    import cpuPkg::*;

    decodeData_t [Slots-1:0] decoded;
    regAddr_t [2*Slots-1:0] rdAddr;
    word_t [2*Slots-1:0] rdData;
    resultData_t [Slots-1:0] execResult;
    logic [Slots-1:0] wrEn;
    regAddr_t [Slots-1:0] wrAddr;
    word_t [Slots-1:0] wrData;

    dualDecode i_decode (
        .fetchIn(fetchIn),
        .decodeOut(decoded)
    );

    // two read ports per slot
    for (genvar i = 0; i < Slots; i++) begin : gRead
        assign rdAddr[2*i] = decoded[i].srcA;
        assign rdAddr[2*i+1] = decoded[i].srcB;
    end

    regFile #(
        .RegCount(RegCount)
    ) i_regFile (
        .clk(clk),
        .arstN(arstN),
        .rdAddr(rdAddr),
        .rdData(rdData),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

    // execute bypasses from the result register outputs
    aluExecute i_execute (
        .clk(clk),
        .arstN(arstN),
        .decodeIn(decoded),
        .readData(rdData),
        .wbIn(resultOut),
        .resultOut(execResult)
    );

    resultStage i_result (
        .clk(clk),
        .arstN(arstN),
        .resultIn(execResult),
        .resultOut(resultOut),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

endmodule

// ==== logic/resultStage.sv ====
`timescale 1ns/10ps

module resultStage (
    input logic clk,
    input logic arstN,
    input cpuPkg::resultData_t [cpuPkg::Slots-1:0] resultIn,
    output cpuPkg::resultData_t [cpuPkg::Slots-1:0] resultOut,
    output logic [cpuPkg::Slots-1:0] wrEn,
    output cpuPkg::regAddr_t [cpuPkg::Slots-1:0] wrAddr,
    output cpuPkg::word_t [cpuPkg::Slots-1:0] wrData
);
    import cpuPkg::*;

    // result register, also the bypass source for execute
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultOut <= '0;
        end else begin
            resultOut <= resultIn;
        end
    end

    // write ports in age order
    // slot 0 is the youngest and lands on the highest port
    // so the register file lets it win on a shared destination
    for (genvar i = 0; i < Slots; i++) begin : gPort
        assign wrEn[Slots-1-i] = resultOut[i].wrEn;
        assign wrAddr[Slots-1-i] = resultOut[i].dest;
        assign wrData[Slots-1-i] = resultOut[i].value;
    end

endmodule

// ==== logic/aluExecute.sv ====
`timescale 1ns/10ps

module aluExecute (
    input logic clk,
    input logic arstN,
    input cpuPkg::decodeData_t [cpuPkg::Slots-1:0] decodeIn,
    input cpuPkg::word_t [2*cpuPkg::Slots-1:0] readData,
    input cpuPkg::resultData_t [cpuPkg::Slots-1:0] wbIn,
    output cpuPkg::resultData_t [cpuPkg::Slots-1:0] resultOut
);
    import cpuPkg::*;

    // issue register
    execData_t [Slots-1:0] issueQ;

    // operands after result-stage bypass
    word_t fwdA [Slots];
    word_t fwdB [Slots];
    // operands after the in-pair cascade
    word_t opA [Slots];
    word_t opB [Slots];

    // result stage bypass with younger slot 0 applied last
    function automatic word_t forward(regAddr_t src, word_t readWord,
                                      resultData_t [Slots-1:0] wb);
        word_t val;
        val = readWord;
        for (int k = Slots - 1; k >= 0; k--) begin
            if (wb[k].wrEn && wb[k].dest == src) begin
                val = wb[k].value;
            end
        end
        if (src == '0) begin
            val = '0;
        end
        return val;
    endfunction

    // older slot of the same pair beats every other source
    function automatic word_t cascade(resultData_t older, regAddr_t src, word_t fallback);
        return (older.wrEn && older.dest == src) ? older.value : fallback;
    endfunction

    function automatic word_t aluCalc(aluOp_t op, word_t a, word_t b, shamt_t sh);
        case (op)
            aluAdd: return a + b;
            aluSub: return a - b;
            aluAnd: return a & b;
            aluOr: return a | b;
            aluXor: return a ^ b;
            aluNor: return ~(a | b);
            aluSlt: return {31'b0, $signed(a) < $signed(b)};
            aluSltu: return {31'b0, a < b};
            // shifts act on rt which arrives as b
            aluSll: return b << sh;
            aluSrl: return b >> sh;
            aluSra: return $signed(b) >>> sh;
            aluLui: return {b[15:0], 16'h0};
            default: return b;
        endcase
    endfunction

    function automatic resultData_t execSlot(execData_t e, word_t a, word_t b);
        resultData_t r;
        word_t immExt;
        word_t opnd;
        immExt = e.dec.ctl.zeroExt ? {16'h0, e.dec.imm} : {{16{e.dec.imm[15]}}, e.dec.imm};
        opnd = e.dec.ctl.immSel ? immExt : b;
        r.valid = e.dec.valid;
        r.pc = e.dec.pc;
        r.dest = e.dec.dest;
        // only alu class commits and never to register 0
        r.wrEn = e.dec.valid && e.dec.ctl.instrClass == classAlu && e.dec.ctl.regWrite
                 && e.dec.dest != '0;
        r.value = aluCalc(e.dec.ctl.aluOp, a, opnd,
                          e.dec.ctl.useShamt ? e.dec.rawInstr[10:6] : shamt_t'(0));
        r.predBranch = e.dec.predBranch;
        r.reserved = e.dec.valid && e.dec.ctl.instrClass == classReserved;
        return r;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueQ <= '0;
        end else begin
            // read ports are paired per slot as a then b
            for (int i = 0; i < Slots; i++) begin
                issueQ[i].dec <= decodeIn[i];
                issueQ[i].readA <= readData[2*i];
                issueQ[i].readB <= readData[2*i+1];
            end
        end
    end

    for (genvar i = 0; i < Slots; i++) begin : gSlot
        assign fwdA[i] = forward(issueQ[i].dec.srcA, issueQ[i].readA, wbIn);
        assign fwdB[i] = forward(issueQ[i].dec.srcB, issueQ[i].readB, wbIn);
        if (i == Slots - 1) begin : gOldest
            // oldest slot has no partner ahead of it
            assign opA[i] = fwdA[i];
            assign opB[i] = fwdB[i];
        end else begin : gCascade
            assign opA[i] = cascade(resultOut[i+1], issueQ[i].dec.srcA, fwdA[i]);
            assign opB[i] = cascade(resultOut[i+1], issueQ[i].dec.srcB, fwdB[i]);
        end
        assign resultOut[i] = execSlot(issueQ[i], opA[i], opB[i]);
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/10ps

module regFile #(
    parameter int RegCount = 32
) (
    input logic clk,
    input logic arstN,
    input cpuPkg::regAddr_t [2*cpuPkg::Slots-1:0] rdAddr,
    output cpuPkg::word_t [2*cpuPkg::Slots-1:0] rdData,
    input logic [cpuPkg::Slots-1:0] wrEn,
    input cpuPkg::regAddr_t [cpuPkg::Slots-1:0] wrAddr,
    input cpuPkg::word_t [cpuPkg::Slots-1:0] wrData
);
    import cpuPkg::*;

    // upper register numbers alias in a smaller file
    localparam int IdxW = $clog2(RegCount);

    word_t regs [RegCount];

    // register 0 is never written and stays at its reset zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < RegCount; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later port wins on the same address
            for (int p = 0; p < Slots; p++) begin
                if (wrEn[p] && wrAddr[p][IdxW-1:0] != '0) begin
                    regs[wrAddr[p][IdxW-1:0]] <= wrData[p];
                end
            end
        end
    end

    // read with write-through and port 1 over port 0
    always_comb begin
        for (int r = 0; r < 2*Slots; r++) begin
            rdData[r] = regs[rdAddr[r][IdxW-1:0]];
            for (int p = 0; p < Slots; p++) begin
                if (wrEn[p] && wrAddr[p][IdxW-1:0] == rdAddr[r][IdxW-1:0]) begin
                    rdData[r] = wrData[p];
                end
            end
            // register 0 reads zero
            if (rdAddr[r][IdxW-1:0] == '0) begin
                rdData[r] = '0;
            end
        end
    end

endmodule

// ==== logic/dualDecode.sv ====
`timescale 1ns/10ps

module dualDecode (
    input cpuPkg::fetchData_t [cpuPkg::Slots-1:0] fetchIn,
    output cpuPkg::decodeData_t [cpuPkg::Slots-1:0] decodeOut
);
    import cpuPkg::*;

    // per-slot return detection from the decoders
    logic [Slots-1:0] isJrRa;

    for (genvar i = 0; i < Slots; i++) begin : gSlot
        instrDecoder i_decoder (
            .valid(fetchIn[i].valid),
            .instr(fetchIn[i].rawInstr),
            .ctl(decodeOut[i].ctl),
            .srcA(decodeOut[i].srcA),
            .srcB(decodeOut[i].srcB),
            .dest(decodeOut[i].dest),
            .isJrRa(isJrRa[i])
        );

        // fields copied straight from fetch
        assign decodeOut[i].valid = fetchIn[i].valid;
        assign decodeOut[i].rawInstr = fetchIn[i].rawInstr;
        assign decodeOut[i].pc = fetchIn[i].pc;

        // low half-word immediate
        assign decodeOut[i].imm = fetchIn[i].rawInstr[15:0];

        // cp0 register number and select
        assign decodeOut[i].cp0ra = {fetchIn[i].rawInstr[15:11], fetchIn[i].rawInstr[2:0]};

        // fetch prediction or a return through ra
        assign decodeOut[i].predBranch = fetchIn[i].predBranch || isJrRa[i];
    end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
    input logic valid,
    input cpuPkg::word_t instr,
    output cpuPkg::ctl_t ctl,
    output cpuPkg::regAddr_t srcA,
    output cpuPkg::regAddr_t srcB,
    output cpuPkg::regAddr_t dest,
    output logic isJrRa
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;

    // raw instruction fields
    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    // jr $ra is treated as a predicted return
    assign isJrRa = valid && opcode == OpSpecial && funct == FnJr && rs == RegRa;

    always_comb begin
        // start from a reserved instruction with no operands
        ctl.aluOp = aluPass;
        ctl.instrClass = classReserved;
        ctl.immSel = 1'b0;
        ctl.zeroExt = 1'b0;
        ctl.useShamt = 1'b0;
        ctl.regWrite = 1'b0;
        srcA = '0;
        srcB = '0;
        dest = '0;
        case (opcode)
            OpSpecial: begin
                // register form writes rd
                ctl.instrClass = classAlu;
                ctl.regWrite = 1'b1;
                srcA = rs;
                srcB = rt;
                dest = rd;
                case (funct)
                    FnAddu: ctl.aluOp = aluAdd;
                    FnSubu: ctl.aluOp = aluSub;
                    FnAnd: ctl.aluOp = aluAnd;
                    FnOr: ctl.aluOp = aluOr;
                    FnXor: ctl.aluOp = aluXor;
                    FnNor: ctl.aluOp = aluNor;
                    FnSlt: ctl.aluOp = aluSlt;
                    FnSltu: ctl.aluOp = aluSltu;
                    FnSll, FnSrl, FnSra: begin
                        // shift rt by the shamt field
                        ctl.useShamt = 1'b1;
                        srcA = '0;
                        if (funct == FnSll) begin
                            ctl.aluOp = aluSll;
                        end else if (funct == FnSrl) begin
                            ctl.aluOp = aluSrl;
                        end else begin
                            ctl.aluOp = aluSra;
                        end
                    end
                    FnJr: begin
                        ctl.instrClass = classJump;
                        ctl.regWrite = 1'b0;
                        srcB = '0;
                        dest = '0;
                    end
                    default: begin
                        // unknown function code
                        ctl.instrClass = classReserved;
                        ctl.regWrite = 1'b0;
                        srcA = '0;
                        srcB = '0;
                        dest = '0;
                    end
                endcase
            end
            OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: begin
                // immediate form writes rt
                ctl.instrClass = classAlu;
                ctl.immSel = 1'b1;
                ctl.regWrite = 1'b1;
                srcA = rs;
                dest = rt;
                case (opcode)
                    OpAddiu: ctl.aluOp = aluAdd;
                    OpSlti: ctl.aluOp = aluSlt;
                    // sltiu compares against the sign-extended immediate
                    OpSltiu: ctl.aluOp = aluSltu;
                    OpAndi: ctl.aluOp = aluAnd;
                    OpOri: ctl.aluOp = aluOr;
                    OpXori: ctl.aluOp = aluXor;
                    default: begin
                        ctl.aluOp = aluLui;
                        srcA = '0;
                    end
                endcase
                // logic immediates are zero extended
                ctl.zeroExt = opcode == OpAndi || opcode == OpOri || opcode == OpXori;
            end
            OpBeq, OpBne: begin
                ctl.instrClass = classBranch;
                ctl.aluOp = aluSub;
                srcA = rs;
                srcB = rt;
            end
            OpJ: ctl.instrClass = classJump;
            OpJal: begin
                // link register as target but no link value
                ctl.instrClass = classJump;
                ctl.regWrite = 1'b1;
                dest = RegRa;
            end
            OpCop0: begin
                if (rs == CopMf) begin
                    ctl.instrClass = classCp0;
                    ctl.regWrite = 1'b1;
                    dest = rt;
                end else if (rs == CopMt) begin
                    // mtc0 carries rt as its data
                    ctl.instrClass = classCp0;
                    srcB = rt;
                end
            end
            default: ctl.instrClass = classReserved;
        endcase
    end

endmodule

// ==== logic/cpuPkg.sv ====
package cpuPkg;

    // issue width of the slice
    localparam int Slots = 2;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0] regAddr_t;
    // rd field in the upper bits and sel in the lower three
    typedef logic [7:0] cp0Addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0] shamt_t;

    // return address register
    localparam regAddr_t RegRa = 5'd31;

    // primary opcodes
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpJ = 6'h02;
    localparam logic [5:0] OpJal = 6'h03;
    localparam logic [5:0] OpBeq = 6'h04;
    localparam logic [5:0] OpBne = 6'h05;
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpSlti = 6'h0a;
    localparam logic [5:0] OpSltiu = 6'h0b;
    localparam logic [5:0] OpAndi = 6'h0c;
    localparam logic [5:0] OpOri = 6'h0d;
    localparam logic [5:0] OpXori = 6'h0e;
    localparam logic [5:0] OpLui = 6'h0f;
    localparam logic [5:0] OpCop0 = 6'h10;

    // function field of special opcode
    localparam logic [5:0] FnSll = 6'h00;
    localparam logic [5:0] FnSrl = 6'h02;
    localparam logic [5:0] FnSra = 6'h03;
    localparam logic [5:0] FnJr = 6'h08;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr = 6'h25;
    localparam logic [5:0] FnXor = 6'h26;
    localparam logic [5:0] FnNor = 6'h27;
    localparam logic [5:0] FnSlt = 6'h2a;
    localparam logic [5:0] FnSltu = 6'h2b;

    // rs field of cop0 opcode
    localparam regAddr_t CopMf = 5'h00;
    localparam regAddr_t CopMt = 5'h04;

    typedef enum logic [3:0] {
        aluAdd, aluSub,
        aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu,
        aluSll, aluSrl, aluSra,
        aluLui, aluPass
    } aluOp_t;

    typedef enum logic [2:0] {
        classAlu, classBranch, classJump, classCp0, classReserved
    } instrClass_t;

    typedef struct packed {
        aluOp_t aluOp;
        instrClass_t instrClass;
        logic immSel;
        logic zeroExt;
        logic useShamt;
        logic regWrite;
    } ctl_t;

    typedef struct packed {
        logic valid;
        word_t rawInstr;
        addr_t pc;
        logic predBranch;
    } fetchData_t;

    typedef struct packed {
        logic valid;
        word_t rawInstr;
        addr_t pc;
        imm_t imm;
        cp0Addr_t cp0ra;
        logic predBranch;
        ctl_t ctl;
        regAddr_t srcA;
        regAddr_t srcB;
        regAddr_t dest;
    } decodeData_t;

    typedef struct packed {
        decodeData_t dec;
        word_t readA;
        word_t readB;
    } execData_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        regAddr_t dest;
        logic wrEn;
        word_t value;
        logic predBranch;
        logic reserved;
    } resultData_t;

endpackage
